// File: verilog/mem_map_pkg.sv
package mem_map_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and address map
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH      = 39;
    localparam int DATA_WIDTH      = 64;
    localparam int PERI_DATA_WIDTH = 32;
    localparam int PERI_ADDR_WIDTH = 32;
    localparam int WALK_ADDR_WIDTH = 56;

    localparam logic [31:0] PERIPHERAL_BASE_ADDR = 32'h10000000;
    localparam logic [31:0] EXT_FIFO_ADDRESS     = 32'he0001030;

    // Qualifying fetch cycles before cache traffic is let through
    localparam int WARMUP_CYCLES = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        REGION_CACHE,
        REGION_PERIPHERAL,
        REGION_FIFO
    } mem_region_t;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        SETTLE,
        WAIT,
        RETURN
    } seq_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        mem_op_t                 op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic [7:0]              byte_enb;
    } mem_req_t;

    typedef struct packed {
        logic                       start;
        logic                       write;
        logic [PERI_ADDR_WIDTH-1:0] addr;
        logic [PERI_DATA_WIDTH-1:0] wdata;
        logic [3:0]                 wstrb;
    } peri_req_t;

    typedef struct packed {
        logic                       valid;
        logic [WALK_ADDR_WIDTH-1:0] addr;
    } walk_req_t;

    typedef struct packed {
        logic                       valid;
        logic [WALK_ADDR_WIDTH-1:0] data;
    } walk_rsp_t;

endpackage

// File: verilog/walk_stub_responder.sv
`timescale 1ns/1ps

module walk_stub_responder
(
    input  logic                    CLK,
    input  logic                    RSTN,
    input  mem_map_pkg::walk_req_t  req,
    output mem_map_pkg::walk_rsp_t  rsp
);

    logic                                    rsp_valid;
    logic [mem_map_pkg::WALK_ADDR_WIDTH-1:0] rsp_data;

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= req.valid;
    end

    // Page table entry stands in as the word address
    always_ff @(posedge CLK)
    begin
        if (req.valid)
            rsp_data <= req.addr >> 2;
    end

    assign rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

// File: verilog/mem_access_router.sv
`timescale 1ns/1ps

module mem_access_router
(
    input  logic                                     CLK,
    input  logic                                     RSTN,
    input  mem_map_pkg::mem_req_t                    proc_req,
    input  logic                                     ins_cache_ready,
    input  logic                                     itlb_ready,
    input  logic                                     fetch_stalled,
    input  logic                                     dat_cache_ready,
    input  logic                                     dtlb_ready,
    input  logic                                     seq_stall_fetch,
    input  logic                                     seq_stall_data,
    input  logic                                     seq_load_valid,
    input  logic [mem_map_pkg::PERI_DATA_WIDTH-1:0]  seq_load_data,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]       dat_cache_rdata,
    output mem_map_pkg::mem_req_t                    cache_req,
    output mem_map_pkg::mem_region_t                 region,
    output logic                                     fetch_enable,
    output logic                                     data_ready,
    output logic                                     warm,
    output logic                                     fifo_wr_enb,
    output logic [mem_map_pkg::DATA_WIDTH-1:0]       fifo_wr_data,
    output logic [mem_map_pkg::DATA_WIDTH-1:0]       load_data
);

    logic [mem_map_pkg::WARMUP_CYCLES-1:0] warm_sr;
    logic                                  fetch_qual;
    logic                                  cache_ok;
    logic                                  fifo_take;

    // FIFO address wins over the peripheral range
    always_comb
    begin
        if (proc_req.addr == mem_map_pkg::EXT_FIFO_ADDRESS)
            region = mem_map_pkg::REGION_FIFO;
        else if (proc_req.addr >= mem_map_pkg::PERIPHERAL_BASE_ADDR)
            region = mem_map_pkg::REGION_PERIPHERAL;
        else
            region = mem_map_pkg::REGION_CACHE;
    end

    assign fetch_qual   = ins_cache_ready & itlb_ready & ~fetch_stalled & ~seq_stall_fetch;
    assign fetch_enable = fetch_qual & warm;
    assign data_ready   = dat_cache_ready & dtlb_ready & ~seq_stall_data;

    // Warm-up chain, one stage per qualifying fetch cycle
    always_ff @(posedge CLK)
    begin
        if (!RSTN)
            warm_sr <= '0;
        else if (fetch_qual)
            warm_sr <= {warm_sr[mem_map_pkg::WARMUP_CYCLES-2:0], 1'b1};
    end

    assign warm = warm_sr[mem_map_pkg::WARMUP_CYCLES-1];

    assign cache_ok = (region == mem_map_pkg::REGION_CACHE) & ins_cache_ready & itlb_ready & warm;

    always_comb
    begin
        cache_req = proc_req;
        if (!cache_ok)
            cache_req.op = mem_map_pkg::OP_NONE;
    end

    ////////////////////////////////////////////////////////////////////////////
    // External FIFO write port
    ////////////////////////////////////////////////////////////////////////////

    assign fifo_take = (region == mem_map_pkg::REGION_FIFO) &
                       (proc_req.op == mem_map_pkg::OP_STORE) & data_ready & warm;

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
            fifo_wr_enb <= 1'b0;
        else
            fifo_wr_enb <= fifo_take;
    end

    always_ff @(posedge CLK)
    begin
        if (fifo_take)
            fifo_wr_data <= proc_req.wdata;
    end

    // Peripheral word replaces cache data for its return cycle
    assign load_data = seq_load_valid ?
        {{(mem_map_pkg::DATA_WIDTH - mem_map_pkg::PERI_DATA_WIDTH){1'b0}}, seq_load_data} :
        dat_cache_rdata;

endmodule

// File: verilog/peripheral_sequencer.sv
`timescale 1ns/1ps

module peripheral_sequencer
(
    input  logic                                     CLK,
    input  logic                                     RSTN,
    input  mem_map_pkg::mem_req_t                    proc_req,
    input  mem_map_pkg::mem_region_t                 region,
    input  logic                                     fetch_enable,
    input  logic                                     data_ready,
    input  logic                                     warm,
    input  logic                                     dat_cache_ready,
    input  logic                                     dtlb_ready,
    input  logic                                     peri_done,
    input  logic [mem_map_pkg::PERI_DATA_WIDTH-1:0]  peri_rdata,
    output mem_map_pkg::peri_req_t                   peri_req,
    output logic                                     seq_stall_fetch,
    output logic                                     seq_stall_data,
    output logic                                     seq_load_valid,
    output logic [mem_map_pkg::PERI_DATA_WIDTH-1:0]  seq_load_data
);

    mem_map_pkg::seq_state_t state_q;
    mem_map_pkg::seq_state_t state_d;

    logic                                    accept;
    logic                                    bp_ok;
    logic                                    busy;
    logic                                    done_window;
    logic                                    done_seen;
    logic                                    done_any;
    logic                                    start_q;
    logic                                    wr_q;
    logic [mem_map_pkg::PERI_ADDR_WIDTH-1:0] addr_q;
    logic [mem_map_pkg::PERI_DATA_WIDTH-1:0] wdata_q;
    logic [3:0]                              wstrb_q;
    logic [mem_map_pkg::PERI_DATA_WIDTH-1:0] rdata_q;

    assign accept = (state_q == mem_map_pkg::IDLE) &
                    (region == mem_map_pkg::REGION_PERIPHERAL) &
                    ((proc_req.op == mem_map_pkg::OP_LOAD) |
                     (proc_req.op == mem_map_pkg::OP_STORE)) &
                    data_ready & fetch_enable & warm;

    assign bp_ok = dat_cache_ready & dtlb_ready;

    assign busy = (state_q == mem_map_pkg::ISSUE) |
                  (state_q == mem_map_pkg::SETTLE) |
                  (state_q == mem_map_pkg::WAIT);

    // Done can only follow the start pulse
    assign done_window = busy & ~start_q;
    assign done_any    = done_seen | (peri_done & done_window);

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            mem_map_pkg::IDLE:
                if (accept)
                    state_d = mem_map_pkg::ISSUE;
            mem_map_pkg::ISSUE:
                if (bp_ok)
                    state_d = mem_map_pkg::SETTLE;
            mem_map_pkg::SETTLE:
                if (bp_ok)
                    state_d = mem_map_pkg::WAIT;
            mem_map_pkg::WAIT:
                if (bp_ok && done_any)
                    state_d = mem_map_pkg::RETURN;
            default:
                state_d = mem_map_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            state_q   <= mem_map_pkg::IDLE;
            start_q   <= 1'b0;
            done_seen <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            start_q <= accept;
            if (accept)
                done_seen <= 1'b0;
            else if (peri_done && done_window)
                done_seen <= 1'b1;
        end
    end

    // Request fields, low half of the processor word
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            wr_q    <= (proc_req.op == mem_map_pkg::OP_STORE);
            addr_q  <= proc_req.addr[mem_map_pkg::PERI_ADDR_WIDTH-1:0];
            wdata_q <= proc_req.wdata[mem_map_pkg::PERI_DATA_WIDTH-1:0];
            wstrb_q <= proc_req.byte_enb[3:0];
        end
        if (peri_done && done_window)
            rdata_q <= peri_rdata;
    end

    assign peri_req = '{start: start_q, write: wr_q, addr: addr_q, wdata: wdata_q, wstrb: wstrb_q};

    assign seq_stall_fetch = busy;
    assign seq_stall_data  = busy;
    assign seq_load_valid  = (state_q == mem_map_pkg::RETURN);
    assign seq_load_data   = rdata_q;

endmodule

// File: verilog/mem_steer_top.sv
`timescale 1ns/1ps

module mem_steer_top
(
    input  logic                                     CLK,
    input  logic                                     RSTN,
    input  mem_map_pkg::mem_req_t                    proc_req,
    input  logic                                     ins_cache_ready,
    input  logic                                     itlb_ready,
    input  logic                                     fetch_stalled,
    input  logic                                     dat_cache_ready,
    input  logic                                     dtlb_ready,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]       dat_cache_rdata,
    output mem_map_pkg::mem_req_t                    cache_req,
    output logic                                     fetch_enable,
    output logic                                     data_ready,
    output logic [mem_map_pkg::DATA_WIDTH-1:0]       load_data,
    output mem_map_pkg::peri_req_t                   peri_req,
    input  logic                                     peri_done,
    input  logic [mem_map_pkg::PERI_DATA_WIDTH-1:0]  peri_rdata,
    output logic                                     fifo_wr_enb,
    output logic [mem_map_pkg::DATA_WIDTH-1:0]       fifo_wr_data,
    input  mem_map_pkg::walk_req_t                   ins_walk_req,
    input  mem_map_pkg::walk_req_t                   dat_walk_req,
    output mem_map_pkg::walk_rsp_t                   ins_walk_rsp,
    output mem_map_pkg::walk_rsp_t                   dat_walk_rsp
);

    mem_map_pkg::mem_region_t                region;
    logic                                    warm;
    logic                                    seq_stall_fetch;
    logic                                    seq_stall_data;
    logic                                    seq_load_valid;
    logic [mem_map_pkg::PERI_DATA_WIDTH-1:0] seq_load_data;

    mem_access_router router
    (
        .CLK             (CLK),
        .RSTN            (RSTN),
        .proc_req        (proc_req),
        .ins_cache_ready (ins_cache_ready),
        .itlb_ready      (itlb_ready),
        .fetch_stalled   (fetch_stalled),
        .dat_cache_ready (dat_cache_ready),
        .dtlb_ready      (dtlb_ready),
        .seq_stall_fetch (seq_stall_fetch),
        .seq_stall_data  (seq_stall_data),
        .seq_load_valid  (seq_load_valid),
        .seq_load_data   (seq_load_data),
        .dat_cache_rdata (dat_cache_rdata),
        .cache_req       (cache_req),
        .region          (region),
        .fetch_enable    (fetch_enable),
        .data_ready      (data_ready),
        .warm            (warm),
        .fifo_wr_enb     (fifo_wr_enb),
        .fifo_wr_data    (fifo_wr_data),
        .load_data       (load_data)
    );

    peripheral_sequencer sequencer
    (
        .CLK             (CLK),
        .RSTN            (RSTN),
        .proc_req        (proc_req),
        .region          (region),
        .fetch_enable    (fetch_enable),
        .data_ready      (data_ready),
        .warm            (warm),
        .dat_cache_ready (dat_cache_ready),
        .dtlb_ready      (dtlb_ready),
        .peri_done       (peri_done),
        .peri_rdata      (peri_rdata),
        .peri_req        (peri_req),
        .seq_stall_fetch (seq_stall_fetch),
        .seq_stall_data  (seq_stall_data),
        .seq_load_valid  (seq_load_valid),
        .seq_load_data   (seq_load_data)
    );

    // Page-walk stand-ins for both TLBs
    walk_stub_responder ins_walk
    (
        .CLK  (CLK),
        .RSTN (RSTN),
        .req  (ins_walk_req),
        .rsp  (ins_walk_rsp)
    );

    walk_stub_responder dat_walk
    (
        .CLK  (CLK),
        .RSTN (RSTN),
        .req  (dat_walk_req),
        .rsp  (dat_walk_rsp)
    );

endmodule

// File: testbench/tb_mem_steer.sv
`timescale 1ns/1ps

module tb_mem_steer;

    localparam int          RESET_CYCLES = 8;
    localparam logic [63:0] CACHE_XOR    = 64'hc3a5_0f1e_7788_9900;
    localparam logic [31:0] PERI_XOR     = 32'h5a5a0000;

    localparam mem_map_pkg::mem_op_t     LD      = mem_map_pkg::OP_LOAD;
    localparam mem_map_pkg::mem_op_t     ST      = mem_map_pkg::OP_STORE;
    localparam mem_map_pkg::mem_region_t R_CACHE = mem_map_pkg::REGION_CACHE;
    localparam mem_map_pkg::mem_region_t R_PERI  = mem_map_pkg::REGION_PERIPHERAL;
    localparam mem_map_pkg::mem_region_t R_FIFO  = mem_map_pkg::REGION_FIFO;

    typedef struct packed {
        mem_map_pkg::mem_op_t     op;
        logic [38:0]              addr;
        logic [63:0]              wdata;
        logic [7:0]               byte_enb;
        logic [3:0]               latency;
        logic                     rand_ready;
        mem_map_pkg::mem_region_t region;
    } stim_t;

    logic                                    CLK;
    logic                                    RSTN;
    mem_map_pkg::mem_req_t                   proc_req;
    logic                                    ins_cache_ready;
    logic                                    itlb_ready;
    logic                                    fetch_stalled;
    logic                                    dat_cache_ready;
    logic                                    dtlb_ready;
    logic [mem_map_pkg::DATA_WIDTH-1:0]      dat_cache_rdata;
    mem_map_pkg::mem_req_t                   cache_req;
    logic                                    fetch_enable;
    logic                                    data_ready;
    logic [mem_map_pkg::DATA_WIDTH-1:0]      load_data;
    mem_map_pkg::peri_req_t                  peri_req;
    logic                                    peri_done;
    logic [mem_map_pkg::PERI_DATA_WIDTH-1:0] peri_rdata;
    logic                                    fifo_wr_enb;
    logic [mem_map_pkg::DATA_WIDTH-1:0]      fifo_wr_data;
    mem_map_pkg::walk_req_t                  ins_walk_req;
    mem_map_pkg::walk_req_t                  dat_walk_req;
    mem_map_pkg::walk_rsp_t                  ins_walk_rsp;
    mem_map_pkg::walk_rsp_t                  dat_walk_rsp;

    stim_t       tests[$];
    string       names[$];
    logic [31:0] seed;
    int          errors;
    int          start_count;
    int          fifo_count;
    logic [63:0] fifo_data;

    mem_steer_top DUT (.*);

    always #5 CLK = ~CLK;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic expect_equal(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic add_test(string name, mem_map_pkg::mem_op_t op, logic [38:0] addr,
                            logic [63:0] wdata, logic [7:0] be, logic [3:0] lat,
                            logic rnd, mem_map_pkg::mem_region_t region);
        stim_t t;
        t = '{op, addr, wdata, be, lat, rnd, region};
        tests.push_back(t);
        names.push_back(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        // name, op, address, wdata, byte enables, peripheral latency, random ready, region
        add_test("cache_load",     LD, 39'h0000_2040, 64'h0, 8'hff, 4'd0, 1'b0, R_CACHE);
        add_test("cache_store",    ST, 39'h0123_4568, 64'h0123_4567_89ab_cdef, 8'h0f, 4'd0,
                 1'b1, R_CACHE);
        add_test("cache_load_bp",  LD, 39'h0fff_fff8, 64'h0, 8'hff, 4'd0, 1'b1, R_CACHE);
        add_test("peri_store",     ST, 39'h1000_0000, 64'hdead_beef_cafe_f00d, 8'h3c, 4'd2,
                 1'b0, R_PERI);
        add_test("peri_store_bp",  ST, 39'h7f00_0104, 64'h0, 8'hf5, 4'd4, 1'b1, R_PERI);
        add_test("peri_load_l1",   LD, 39'h1000_0010, 64'h0, 8'hff, 4'd1, 1'b1, R_PERI);
        add_test("peri_load_l2",   LD, 39'h2000_0020, 64'h0, 8'hff, 4'd2, 1'b1, R_PERI);
        add_test("peri_load_l3",   LD, 39'h3abc_0030, 64'h0, 8'hff, 4'd3, 1'b1, R_PERI);
        add_test("peri_load_l4",   LD, 39'h4000_0ff0, 64'h0, 8'hff, 4'd4, 1'b1, R_PERI);
        add_test("peri_load_l5",   LD, 39'h9000_1000, 64'h0, 8'hff, 4'd5, 1'b1, R_PERI);
        add_test("peri_load_l6",   LD, 39'hffff_fffc, 64'h0, 8'hff, 4'd6, 1'b1, R_PERI);
        add_test("fifo_store",     ST, 39'he000_1030, 64'h0f0f_0f0f_0f0f_0f0f, 8'hff, 4'd0,
                 1'b0, R_FIFO);
        add_test("fifo_store_bp",  ST, 39'he000_1030, 64'h0, 8'hff, 4'd0, 1'b1, R_FIFO);
        add_test("fifo_load",      LD, 39'he000_1030, 64'h0, 8'hff, 4'd0, 1'b1, R_FIFO);
        add_test("near_fifo_load", LD, 39'he000_1034, 64'h0, 8'hff, 4'd3, 1'b1, R_PERI);
    endtask

    task automatic drive_idle();
        proc_req = '0;
        dat_cache_ready = 1'b1;
        peri_done = 1'b0;
    endtask

    // Counts strobes on one falling edge
    task automatic observe_cycle();
        @(negedge CLK);
        if (peri_req.start)
            start_count++;
        if (fifo_wr_enb)
        begin
            fifo_count++;
            fifo_data = fifo_wr_data;
        end
        if (ins_walk_rsp.valid || dat_walk_rsp.valid)
        begin
            errors++;
            $display("A walk response appeared without a walk request at %0t", $time);
        end
    endtask

    task automatic run_test(int idx);
        stim_t       t;
        string       name;
        logic [63:0] wdata;
        logic [31:0] rdata;
        int          countdown;
        int          ready_edges;
        bit          accepted;
        bit          done_seen;
        bit          in_return;
        bit          taken;
        t = tests[idx];
        name = names[idx];
        wdata = t.wdata ^ {next_random(), next_random()};
        rdata = t.addr[31:0] ^ PERI_XOR;
        countdown = 0;
        ready_edges = 0;
        accepted = 0;
        done_seen = 0;
        in_return = 0;
        taken = 0;
        start_count = 0;
        fifo_count = 0;
        @(posedge CLK);
        #1;
        proc_req = '{op: t.op, addr: t.addr, wdata: wdata, byte_enb: t.byte_enb};
        dat_cache_rdata = {25'd0, t.addr} ^ CACHE_XOR;
        while (!taken)
        begin
            // The return cycle needs ready, or the peripheral word is lost
            dat_cache_ready = (t.rand_ready && !in_return) ? (next_random() % 4 != 0) : 1'b1;
            observe_cycle();
            if (peri_req.start)
            begin
                countdown = t.latency;
                expect_equal({name, " start.write"}, t.op == ST, peri_req.write);
                expect_equal({name, " start.addr"}, t.addr[31:0], peri_req.addr);
                expect_equal({name, " start.wdata"}, wdata[31:0], peri_req.wdata);
                expect_equal({name, " start.wstrb"}, t.byte_enb[3:0], peri_req.wstrb);
            end
            if (t.region == R_CACHE)
                expect_equal({name, " cache_req"}, proc_req, cache_req);
            else
                expect_equal({name, " cache_req.op"}, mem_map_pkg::OP_NONE, cache_req.op);
            if (in_return)
            begin
                taken = 1;
                expect_equal({name, " return data_ready"}, 1, data_ready);
                if (t.op == LD)
                    expect_equal({name, " load_data"}, {32'd0, rdata}, load_data);
            end
            else if (accepted)
            begin
                expect_equal({name, " busy data_ready"}, 0, data_ready);
                expect_equal({name, " fetch_enable"}, 0, fetch_enable);
            end
            else if (data_ready)
            begin
                if (t.region == R_PERI)
                    accepted = 1;
                else
                begin
                    taken = 1;
                    if (t.region == R_CACHE && t.op == LD)
                        expect_equal({name, " load_data"}, {25'd0, t.addr} ^ CACHE_XOR,
                                     load_data);
                end
            end
            @(posedge CLK);
            #1;
            // Accept edge, then one ready edge each for ISSUE, SETTLE and WAIT
            if (peri_done)
                done_seen = 1;
            if (accepted && !in_return && dat_cache_ready)
            begin
                ready_edges++;
                if (ready_edges >= 4 && done_seen)
                    in_return = 1;
            end
            // Peripheral model, done after the entry's latency
            peri_done = 1'b0;
            peri_rdata = next_random();
            if (countdown > 0)
            begin
                countdown--;
                if (countdown == 0)
                begin
                    peri_done = 1'b1;
                    peri_rdata = rdata;
                end
            end
        end
        drive_idle();
        repeat (2) observe_cycle();
        expect_equal({name, " start pulses"}, (t.region == R_PERI) ? 1 : 0, start_count);
        expect_equal({name, " fifo strobes"}, (t.region == R_FIFO && t.op == ST) ? 1 : 0,
                     fifo_count);
        if (t.region == R_FIFO && t.op == ST)
            expect_equal({name, " fifo_wr_data"}, wdata, fifo_data);
    endtask

    task automatic check_walk(string name, bit use_dat, logic [55:0] addr);
        @(posedge CLK);
        #1;
        if (use_dat)
            dat_walk_req = '{valid: 1'b1, addr: addr};
        else
            ins_walk_req = '{valid: 1'b1, addr: addr};
        @(negedge CLK);
        expect_equal({name, " early valid"}, 0, {ins_walk_rsp.valid, dat_walk_rsp.valid});
        @(posedge CLK);
        #1;
        ins_walk_req.valid = 1'b0;
        dat_walk_req.valid = 1'b0;
        @(negedge CLK);
        expect_equal({name, " valid"}, use_dat ? 2'b01 : 2'b10,
                     {ins_walk_rsp.valid, dat_walk_rsp.valid});
        expect_equal({name, " data"}, addr >> 2, use_dat ? dat_walk_rsp.data : ins_walk_rsp.data);
        @(negedge CLK);
        expect_equal({name, " late valid"}, 0, {ins_walk_rsp.valid, dat_walk_rsp.valid});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int          fe_wait;
        logic [31:0] rnd;
        logic [55:0] walk_addr;
        CLK = 1'b0;
        RSTN = 1'b0;
        seed = 32'h76a8;
        errors = 0;
        proc_req = '0;
        ins_cache_ready = 1'b1;
        itlb_ready = 1'b1;
        fetch_stalled = 1'b0;
        dat_cache_ready = 1'b1;
        dtlb_ready = 1'b1;
        dat_cache_rdata = '0;
        peri_done = 1'b0;
        peri_rdata = '0;
        ins_walk_req = '{valid: 1'b1, addr: 56'h40};
        dat_walk_req = '{valid: 1'b1, addr: 56'h80};
        build_table();
        repeat (RESET_CYCLES)
        begin
            @(posedge CLK);
            #1;
            expect_equal("reset outputs", 0, {peri_req.start, fifo_wr_enb, ins_walk_rsp.valid,
                                              dat_walk_rsp.valid, fetch_enable});
        end
        RSTN = 1'b1;
        ins_walk_req.valid = 1'b0;
        dat_walk_req.valid = 1'b0;
        proc_req = '{op: LD, addr: 39'h800, wdata: 64'h0, byte_enb: 8'hff};
        // Cache stays shut until the warm-up chain fills
        fe_wait = 0;
        @(negedge CLK);
        while (!fetch_enable && fe_wait < 20)
        begin
            expect_equal("warmup cache_req.op", mem_map_pkg::OP_NONE, cache_req.op);
            fe_wait++;
            @(negedge CLK);
        end
        expect_equal("warmup cycles", mem_map_pkg::WARMUP_CYCLES, fe_wait);
        expect_equal("warm cache_req.op", LD, cache_req.op);
        for (int i = 0; i < tests.size(); i++)
            run_test(i);
        for (int i = 0; i < 4; i++)
        begin
            rnd = next_random();
            walk_addr = {rnd[23:0], next_random()};
            check_walk((i % 2 == 1) ? "dat_walk" : "ins_walk", i % 2 == 1, walk_addr);
        end
        $display("Checks done with %0d errors", errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        int limit;
        #1;
        limit = RESET_CYCLES + 200 * names.size();
        repeat (limit) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: compile.f
verilog/mem_map_pkg.sv
verilog/walk_stub_responder.sv
verilog/mem_access_router.sv
verilog/peripheral_sequencer.sv
verilog/mem_steer_top.sv
testbench/tb_mem_steer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_mem_steer -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/Vtb_mem_steer); then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi

exit 1
